/* fme_buf_pkg.sv */
// shared widths, types and bank constants for the FME buffer stage
// referenced by scoped names from the RAM, the rotator, the ping-pong unit and the top
package fme_buf_pkg;

  // --------------------
  // widths
  localparam int unsigned PIXEL_W         = 8;
  localparam int unsigned FMV_W           = 10;
  localparam int unsigned MV_ADDR_W       = 6;
  localparam int unsigned BLK_COORD_W     = 4;
  localparam int unsigned PRED_BLK_PIXELS = 16;
  localparam int unsigned MV_DATA_W       = 2 * FMV_W;
  localparam int unsigned PRED_ADDR_W     = 2 * BLK_COORD_W;
  localparam int unsigned PRED_DATA_W     = PRED_BLK_PIXELS * PIXEL_W;

  // --------------------
  // types
  typedef logic [PIXEL_W-1:0]     pixel_t;
  typedef logic [MV_DATA_W-1:0]   mv_pair_t;
  typedef logic [MV_ADDR_W-1:0]   mv_addr_t;
  typedef logic [BLK_COORD_W-1:0] blk_coord_t;
  typedef logic [PRED_ADDR_W-1:0] pred_addr_t;
  typedef pixel_t [PRED_BLK_PIXELS-1:0] pred_blk_t;
  typedef logic [1:0]             rot_sel_t;

  typedef struct packed {
    logic     wren;
    mv_addr_t addr;
    mv_pair_t data;
  } mv_wr_t;

  typedef struct packed {
    logic     ren;
    mv_addr_t addr;
  } mv_rd_t;

  typedef struct packed {
    logic       en;
    blk_coord_t blk_x;
    blk_coord_t blk_y;
    pred_blk_t  data;
  } pred_wr_t;

  typedef struct packed {
    logic       en;
    blk_coord_t blk_x;
    blk_coord_t blk_y;
  } pred_rd_t;

  // --------------------
  // bank constants
  localparam int unsigned NUM_MV_BANKS  = 3;
  localparam int unsigned NUM_MV_REQ    = 3;
  localparam int unsigned NUM_PRED_BUFS = 2;
  localparam rot_sel_t    ROT_SEL_IDLE  = 2'd3;

  // requester order is fme, mc, db; offset added to the stage select
  localparam int unsigned REQ_BANK_OFS [NUM_MV_REQ] = '{0, 2, 1};

  // bank served to a requester with the given offset
  function automatic rot_sel_t bank_of(rot_sel_t sel, int unsigned ofs);
    int unsigned sum;
    sum = int'(sel) + ofs;
    return rot_sel_t'(sum % NUM_MV_BANKS);
  endfunction

endpackage

/* fme_dp_ram.sv */
`timescale 1ns/1ns
// simple dual-port RAM, one write port and one registered read port
// used for the motion-vector banks and the prediction buffers
module fme_dp_ram #(
  parameter int unsigned DATA_W = 20,
  parameter int unsigned ADDR_W = 6
) (
  input  logic              clk,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o
);

  localparam int unsigned DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // read every cycle, old data on a same-address collision
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

/* fme_mv_rotator.sv */
`timescale 1ns/1ns
// three motion-vector banks rotating under the stage select
// FME owns bank sel, MC reads the bank from one stage back, DB the one before that
// select 3 parks the rotation, no writes and zero read data
module fme_mv_rotator (
  input  logic                  clk,
  input  logic                  reset_i,
  input  fme_buf_pkg::rot_sel_t sel_i,
  input  fme_buf_pkg::mv_wr_t   fme_wr_i,
  input  fme_buf_pkg::mv_rd_t   fme_rd_i,
  input  fme_buf_pkg::mv_rd_t   mc_rd_i,
  input  fme_buf_pkg::mv_rd_t   db_rd_i,
  output fme_buf_pkg::mv_pair_t fme_mv_o,
  output fme_buf_pkg::mv_pair_t mc_mv_o,
  output fme_buf_pkg::mv_pair_t db_mv_o
);

  fme_buf_pkg::mv_rd_t   req_rd    [fme_buf_pkg::NUM_MV_REQ];
  fme_buf_pkg::mv_pair_t req_mv    [fme_buf_pkg::NUM_MV_REQ];
  fme_buf_pkg::mv_pair_t bank_data [fme_buf_pkg::NUM_MV_BANKS];
  fme_buf_pkg::rot_sel_t sel_q;

  assign req_rd[0] = fme_rd_i;
  assign req_rd[1] = mc_rd_i;
  assign req_rd[2] = db_rd_i;

  // --------------------
  // banks
  for (genvar b = 0; b < fme_buf_pkg::NUM_MV_BANKS; b++) begin : g_bank
    logic                  wr_en;
    fme_buf_pkg::mv_addr_t rd_addr;

    assign wr_en = fme_wr_i.wren && (sel_i == fme_buf_pkg::rot_sel_t'(b));

    // each bank has exactly one reader per legal select
    always_comb begin
      rd_addr = '0;
      for (int r = 0; r < fme_buf_pkg::NUM_MV_REQ; r++) begin
        if (fme_buf_pkg::bank_of(sel_i, fme_buf_pkg::REQ_BANK_OFS[r]) ==
            fme_buf_pkg::rot_sel_t'(b)) begin
          rd_addr = req_rd[r].addr;
        end
      end
    end

    fme_dp_ram #(
      .DATA_W (fme_buf_pkg::MV_DATA_W),
      .ADDR_W (fme_buf_pkg::MV_ADDR_W)
    ) i_mv_ram (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (fme_wr_i.addr),
      .wr_data_i (fme_wr_i.data),
      .rd_addr_i (rd_addr),
      .rd_data_o (bank_data[b])
    );
  end

  // select seen at the read edge
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sel_q <= fme_buf_pkg::ROT_SEL_IDLE;
    end else begin
      sel_q <= sel_i;
    end
  end

  // --------------------
  // read data per requester
  for (genvar r = 0; r < fme_buf_pkg::NUM_MV_REQ; r++) begin : g_req
    logic                  rd_vld_q;
    fme_buf_pkg::mv_pair_t hold_q;

    always_ff @(posedge clk) begin
      if (reset_i) begin
        rd_vld_q <= 1'b0;
        hold_q   <= '0;
      end else begin
        rd_vld_q <= req_rd[r].ren;
        if (rd_vld_q) begin
          hold_q <= req_mv[r];
        end
      end
    end

    // fresh bank data in the cycle after the read, held value otherwise
    assign req_mv[r] = !rd_vld_q                          ? hold_q :
                       (sel_q == fme_buf_pkg::ROT_SEL_IDLE) ? '0 :
                       bank_data[fme_buf_pkg::bank_of(sel_q, fme_buf_pkg::REQ_BANK_OFS[r])];
  end

  assign fme_mv_o = req_mv[0];
  assign mc_mv_o  = req_mv[1];
  assign db_mv_o  = req_mv[2];

endmodule

/* fme_pred_pingpong.sv */
`timescale 1ns/1ns
// ping-pong prediction buffers, one 4x4 block per entry
// FME writes buffer sel, MC reads and writes the other one
module fme_pred_pingpong (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   sel_i,
  input  fme_buf_pkg::pred_wr_t  fme_wr_i,
  input  fme_buf_pkg::pred_wr_t  mc_wr_i,
  input  fme_buf_pkg::pred_rd_t  mc_rd_i,
  output fme_buf_pkg::pred_blk_t mc_pred_o
);

  fme_buf_pkg::pred_blk_t buf_data [fme_buf_pkg::NUM_PRED_BUFS];
  fme_buf_pkg::pred_addr_t rd_addr;
  fme_buf_pkg::pred_blk_t  hold_q;
  logic                    sel_q;
  logic                    rd_vld_q;

  // block y in the upper half of the address
  assign rd_addr = {mc_rd_i.blk_y, mc_rd_i.blk_x};

  // --------------------
  // buffers
  for (genvar p = 0; p < fme_buf_pkg::NUM_PRED_BUFS; p++) begin : g_buf
    fme_buf_pkg::pred_wr_t   wr;
    fme_buf_pkg::pred_addr_t wr_addr;

    assign wr      = (sel_i == 1'(p)) ? fme_wr_i : mc_wr_i;
    assign wr_addr = {wr.blk_y, wr.blk_x};

    fme_dp_ram #(
      .DATA_W (fme_buf_pkg::PRED_DATA_W),
      .ADDR_W (fme_buf_pkg::PRED_ADDR_W)
    ) i_pred_ram (
      .clk       (clk),
      .wr_en_i   (wr.en),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr.data),
      .rd_addr_i (rd_addr),
      .rd_data_o (buf_data[p])
    );
  end

  // --------------------
  // MC read data
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sel_q    <= 1'b0;
      rd_vld_q <= 1'b0;
      hold_q   <= '0;
    end else begin
      sel_q    <= sel_i;
      rd_vld_q <= mc_rd_i.en;
      if (rd_vld_q) begin
        hold_q <= mc_pred_o;
      end
    end
  end

  // MC side is the buffer FME is not writing
  assign mc_pred_o = rd_vld_q ? buf_data[!sel_q] : hold_q;

endmodule

/* fme_buf_top.sv */
`timescale 1ns/1ns
// buffer stage around the FME engine
// motion-vector bank rotation plus ping-pong prediction buffers
// all reads have one cycle of latency and hold until the next read
module fme_buf_top (
  input  logic                   clk,
  input  logic                   reset_i,

  // motion vectors
  input  fme_buf_pkg::mv_wr_t    fme_mv_wr_i,
  input  fme_buf_pkg::mv_rd_t    fme_mv_rd_i,
  input  fme_buf_pkg::mv_rd_t    mc_mv_rd_i,
  input  fme_buf_pkg::mv_rd_t    db_mv_rd_i,
  input  fme_buf_pkg::rot_sel_t  sel_mod_3_i,
  output fme_buf_pkg::mv_pair_t  fme_mv_o,
  output fme_buf_pkg::mv_pair_t  mc_mv_o,
  output fme_buf_pkg::mv_pair_t  db_mv_o,

  // prediction
  input  fme_buf_pkg::pred_wr_t  fme_pred_wr_i,
  input  fme_buf_pkg::pred_wr_t  mc_pred_wr_i,
  input  fme_buf_pkg::pred_rd_t  mc_pred_rd_i,
  input  logic                   sel_mod_2_i,
  output fme_buf_pkg::pred_blk_t mc_pred_o
);

  // --------------------
  // motion-vector banks
  fme_mv_rotator i_fme_mv_rotator (
    .clk      (clk),
    .reset_i  (reset_i),
    .sel_i    (sel_mod_3_i),
    .fme_wr_i (fme_mv_wr_i),
    .fme_rd_i (fme_mv_rd_i),
    .mc_rd_i  (mc_mv_rd_i),
    .db_rd_i  (db_mv_rd_i),
    .fme_mv_o (fme_mv_o),
    .mc_mv_o  (mc_mv_o),
    .db_mv_o  (db_mv_o)
  );

  // --------------------
  // prediction buffers
  fme_pred_pingpong i_fme_pred_pingpong (
    .clk       (clk),
    .reset_i   (reset_i),
    .sel_i     (sel_mod_2_i),
    .fme_wr_i  (fme_pred_wr_i),
    .mc_wr_i   (mc_pred_wr_i),
    .mc_rd_i   (mc_pred_rd_i),
    .mc_pred_o (mc_pred_o)
  );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ns
// free-running testbench clock
// half a period low, then half a period high
module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

/* tb_fme_buf_top.sv */
`timescale 1ns/1ns
// testbench for the FME buffer stage
// builds a row table with reference models, applies one row per clock
// and checks each result one cycle after its row
module tb_fme_buf_top;

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned DRIVE_DLY  = 1;
  localparam int unsigned MAX_ROWS   = 96;

  // row operations
  localparam logic [2:0] OP_NONE        = 3'd0;
  localparam logic [2:0] OP_MV_WR       = 3'd1;
  localparam logic [2:0] OP_MV_RD       = 3'd2;
  localparam logic [2:0] OP_FME_PRED_WR = 3'd3;
  localparam logic [2:0] OP_MC_PRED_WR  = 3'd4;
  localparam logic [2:0] OP_PRED_RD     = 3'd5;

  // output checked one cycle after the row
  localparam logic [2:0] CHK_NONE = 3'd0;
  localparam logic [2:0] CHK_FME  = 3'd1;
  localparam logic [2:0] CHK_MC   = 3'd2;
  localparam logic [2:0] CHK_DB   = 3'd3;
  localparam logic [2:0] CHK_PRED = 3'd4;

  typedef struct packed {
    logic [2:0]              op;
    logic [2:0]              chk;
    fme_buf_pkg::rot_sel_t   sel3;
    logic                    sel2;
    fme_buf_pkg::mv_addr_t   addr;
    fme_buf_pkg::blk_coord_t blk_x;
    fme_buf_pkg::blk_coord_t blk_y;
    logic [127:0]            data;
    logic [127:0]            exp;
  } row_t;

  logic                   clk;
  logic                   reset_i;
  fme_buf_pkg::mv_wr_t    fme_mv_wr_i;
  fme_buf_pkg::mv_rd_t    fme_mv_rd_i;
  fme_buf_pkg::mv_rd_t    mc_mv_rd_i;
  fme_buf_pkg::mv_rd_t    db_mv_rd_i;
  fme_buf_pkg::rot_sel_t  sel_mod_3_i;
  fme_buf_pkg::mv_pair_t  fme_mv_o;
  fme_buf_pkg::mv_pair_t  mc_mv_o;
  fme_buf_pkg::mv_pair_t  db_mv_o;
  fme_buf_pkg::pred_wr_t  fme_pred_wr_i;
  fme_buf_pkg::pred_wr_t  mc_pred_wr_i;
  fme_buf_pkg::pred_rd_t  mc_pred_rd_i;
  logic                   sel_mod_2_i;
  fme_buf_pkg::pred_blk_t mc_pred_o;

  row_t         rows [MAX_ROWS];
  string        row_names [MAX_ROWS];
  int           row_cnt = 0;
  int           err_cnt = 0;
  int           seed = 14;
  logic         table_ready = 1'b0;
  logic [19:0]  mv_model [3][64];
  logic [127:0] pred_model [2][256];
  logic [127:0] last_out [5] = '{default: '0};

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) i_tb_clk_gen (.clk_o(clk));

  fme_buf_top i_fme_buf_top (
    .clk           (clk),
    .reset_i       (reset_i),
    .fme_mv_wr_i   (fme_mv_wr_i),
    .fme_mv_rd_i   (fme_mv_rd_i),
    .mc_mv_rd_i    (mc_mv_rd_i),
    .db_mv_rd_i    (db_mv_rd_i),
    .sel_mod_3_i   (sel_mod_3_i),
    .fme_mv_o      (fme_mv_o),
    .mc_mv_o       (mc_mv_o),
    .db_mv_o       (db_mv_o),
    .fme_pred_wr_i (fme_pred_wr_i),
    .mc_pred_wr_i  (mc_pred_wr_i),
    .mc_pred_rd_i  (mc_pred_rd_i),
    .sel_mod_2_i   (sel_mod_2_i),
    .mc_pred_o     (mc_pred_o)
  );

  // --------------------
  // table building
  task automatic add_row(input string name, input logic [2:0] op, input logic [2:0] chk,
                         input fme_buf_pkg::rot_sel_t sel3, input logic sel2,
                         input fme_buf_pkg::mv_addr_t addr,
                         input fme_buf_pkg::blk_coord_t bx, input fme_buf_pkg::blk_coord_t by);
    row_t row;
    int   bank;
    row       = '0;
    row.op    = op;
    row.chk   = chk;
    row.sel3  = sel3;
    row.sel2  = sel2;
    row.addr  = addr;
    row.blk_x = bx;
    row.blk_y = by;
    row.data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    // MC reads the bank one stage behind FME, DB the one two stages behind
    bank = (int'(sel3) + ((chk == CHK_MC) ? 2 : (chk == CHK_DB) ? 1 : 0)) % 3;
    case (op)
      OP_MV_WR: begin
        row.data = 128'(row.data[19:0]);
        if (sel3 != 2'd3) begin
          mv_model[sel3][addr] = row.data[19:0];
        end
      end
      OP_MV_RD:       last_out[chk] = (sel3 == 2'd3) ? '0 : 128'(mv_model[bank][addr]);
      OP_FME_PRED_WR: pred_model[sel2][{by, bx}] = row.data;
      OP_MC_PRED_WR:  pred_model[!sel2][{by, bx}] = row.data;
      OP_PRED_RD:     last_out[CHK_PRED] = pred_model[!sel2][{by, bx}];
      default:        ;
    endcase
    // a row without a read expects the held value
    row.exp            = last_out[chk];
    rows[row_cnt]      = row;
    row_names[row_cnt] = name;
    row_cnt++;
  endtask

  task automatic build_table();
    for (int s = 0; s < 3; s++) begin
      for (int k = 0; k < 3; k++) begin
        add_row($sformatf("fme_wr s%0d k%0d", s, k), OP_MV_WR, CHK_NONE, 2'(s), 1'b0,
                6'(k * 7 + s), '0, '0);
      end
      for (int k = 0; k < 3; k++) begin
        add_row($sformatf("fme_rd s%0d k%0d", s, k), OP_MV_RD, CHK_FME, 2'(s), 1'b0,
                6'(k * 7 + s), '0, '0);
      end
    end
    // each stage's bank seen later by MC and DB
    for (int s = 0; s < 3; s++) begin
      for (int k = 0; k < 3; k++) begin
        add_row($sformatf("mc_rd s%0d k%0d", s, k), OP_MV_RD, CHK_MC, 2'((s + 1) % 3), 1'b0,
                6'(k * 7 + s), '0, '0);
        add_row($sformatf("db_rd s%0d k%0d", s, k), OP_MV_RD, CHK_DB, 2'((s + 2) % 3), 1'b0,
                6'(k * 7 + s), '0, '0);
      end
    end
    // select 3 drops writes and zeroes reads
    for (int k = 0; k < 2; k++) begin
      add_row("idle_wr", OP_MV_WR, CHK_NONE, 2'd3, 1'b0, 6'(k * 7), '0, '0);
    end
    add_row("idle_rd fme", OP_MV_RD, CHK_FME, 2'd3, 1'b0, 6'd0, '0, '0);
    add_row("idle_rd mc", OP_MV_RD, CHK_MC, 2'd3, 1'b0, 6'd2, '0, '0);
    add_row("idle_rd db", OP_MV_RD, CHK_DB, 2'd3, 1'b0, 6'd1, '0, '0);
    for (int k = 0; k < 2; k++) begin
      add_row($sformatf("after_idle k%0d", k), OP_MV_RD, CHK_FME, 2'd0, 1'b0,
              6'(k * 7), '0, '0);
    end
    // hold across select changes
    add_row("hold_prep mc", OP_MV_RD, CHK_MC, 2'd1, 1'b0, 6'd7, '0, '0);
    add_row("hold_prep db", OP_MV_RD, CHK_DB, 2'd1, 1'b0, 6'd9, '0, '0);
    add_row("hold fme", OP_NONE, CHK_FME, 2'd2, 1'b1, '0, '0, '0);
    add_row("hold mc", OP_NONE, CHK_MC, 2'd0, 1'b0, '0, '0, '0);
    add_row("hold db", OP_NONE, CHK_DB, 2'd3, 1'b1, '0, '0, '0);
    add_row("hold fme again", OP_NONE, CHK_FME, 2'd1, 1'b0, '0, '0, '0);
    // ping-pong
    for (int k = 0; k < 3; k++) begin
      add_row($sformatf("fme_pred_wr k%0d", k), OP_FME_PRED_WR, CHK_NONE, 2'd3, 1'b0, '0,
              4'(k + 1), 4'(2 * k));
    end
    for (int k = 0; k < 3; k++) begin
      add_row($sformatf("mc_pred_rd k%0d", k), OP_PRED_RD, CHK_PRED, 2'd3, 1'b1, '0,
              4'(k + 1), 4'(2 * k));
    end
    add_row("mc_pred_wr", OP_MC_PRED_WR, CHK_NONE, 2'd3, 1'b1, '0, 4'd5, 4'd9);
    add_row("fme_pred_wr other", OP_FME_PRED_WR, CHK_NONE, 2'd3, 1'b1, '0, 4'd5, 4'd9);
    add_row("mc_pred_rd own", OP_PRED_RD, CHK_PRED, 2'd3, 1'b1, '0, 4'd5, 4'd9);
    add_row("mc_pred_rd flipped", OP_PRED_RD, CHK_PRED, 2'd3, 1'b0, '0, 4'd5, 4'd9);
    add_row("hold pred", OP_NONE, CHK_PRED, 2'd3, 1'b1, '0, '0, '0);
    add_row("hold pred again", OP_NONE, CHK_PRED, 2'd0, 1'b0, '0, '0, '0);
  endtask

  // --------------------
  // driving and checking
  task automatic apply_row(input row_t row);
    sel_mod_3_i   = row.sel3;
    sel_mod_2_i   = row.sel2;
    fme_mv_wr_i   = '{wren: row.op == OP_MV_WR, addr: row.addr, data: row.data[19:0]};
    fme_mv_rd_i   = '{ren: (row.op == OP_MV_RD) && (row.chk == CHK_FME), addr: row.addr};
    mc_mv_rd_i    = '{ren: (row.op == OP_MV_RD) && (row.chk == CHK_MC), addr: row.addr};
    db_mv_rd_i    = '{ren: (row.op == OP_MV_RD) && (row.chk == CHK_DB), addr: row.addr};
    fme_pred_wr_i = '{en: row.op == OP_FME_PRED_WR, blk_x: row.blk_x, blk_y: row.blk_y,
                      data: row.data};
    mc_pred_wr_i  = '{en: row.op == OP_MC_PRED_WR, blk_x: row.blk_x, blk_y: row.blk_y,
                      data: row.data};
    mc_pred_rd_i  = '{en: row.op == OP_PRED_RD, blk_x: row.blk_x, blk_y: row.blk_y};
  endtask

  function automatic logic [127:0] output_of(input logic [2:0] chk);
    case (chk)
      CHK_FME:  return 128'(fme_mv_o);
      CHK_MC:   return 128'(mc_mv_o);
      CHK_DB:   return 128'(db_mv_o);
      CHK_PRED: return 128'(mc_pred_o);
      default:  return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  initial begin
    reset_i = 1'b1;
    apply_row('0);
    sel_mod_3_i = 2'd3;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    #DRIVE_DLY;
    reset_i = 1'b0;
    for (int c = CHK_FME; c <= CHK_PRED; c++) begin
      check_value($sformatf("reset output %0d", c), '0, output_of(3'(c)));
    end
    for (int i = 0; i < row_cnt; i++) begin
      apply_row(rows[i]);
      @(posedge clk);
      #DRIVE_DLY;
      if (rows[i].chk != CHK_NONE) begin
        check_value(row_names[i], rows[i].exp, output_of(rows[i].chk));
      end
    end
    apply_row('0);
    if (err_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "checks failed");
    end
  end

  // generous bound of four cycles per row plus reset
  initial begin : watchdog
    wait (table_ready);
    #((row_cnt * 4 + 40) * CLK_PERIOD);
    $display("timeout: the table rows did not complete in the allowed time");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* fme_buf_top.f */
fme_buf_pkg.sv
fme_dp_ram.sv
fme_mv_rotator.sv
fme_pred_pingpong.sv
fme_buf_top.sv
tb_clk_gen.sv
tb_fme_buf_top.sv

/* Makefile */
# Verilator build and run of the FME buffer stage testbench
TOP = tb_fme_buf_top

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails on a reported error"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f fme_buf_top.f -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
